/* Makefile */
# Verilator build and run of the single-cycle CPU testbench
TOP = cpuTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f *.sv program.hex
	verilator --binary -j 0 --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu
	import cpuPkg::*;
(
	input  logic [2:0]  aluOp,
	input  logic [31:0] a,                       // rs data
	input  logic [31:0] b,                       // rt data or extended immediate
	output logic [31:0] result,
	output logic        zero                     // Drives the branch decision
);

	logic lessThan;                              // Signed compare for slt

	assign lessThan = $signed(a) < $signed(b);

	always_comb
	begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;              // Also used by beq and bne
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);
			aluSlt: result = {31'b0, lessThan};
			aluLui: result = {b[15:0], 16'b0};   // Low half of b is imm16
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* control.sv */
`timescale 1ns/100ps
`default_nettype none

module control
	import cpuPkg::*;
(
	input  logic [5:0] op,
	input  logic [5:0] funct,
	output logic [1:0] regDst,                   // Write register select
	output logic       aluSrc,                   // ALU B from immediate
	output logic       extZero,                  // Zero-extend imm16
	output logic [2:0] aluOp,
	output logic       memWrite,
	output logic [1:0] wbSel,
	output logic       regWrite,
	output logic       branchEq,
	output logic       branchNe,
	output logic [1:0] jumpSel
);

	always_comb
	begin
		regDst   = dstRt;                        // Defaults give a no-op
		aluSrc   = 1'b0;
		extZero  = 1'b0;
		aluOp    = aluAdd;
		memWrite = 1'b0;
		wbSel    = wbAlu;
		regWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jumpSel  = pcSeq;
		case (op)
			opRType:
			begin
				regDst   = dstRd;
				regWrite = 1'b1;                 // Cleared below for jr and unknown funct
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr:  aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSlt: aluOp = aluSlt;
					fnJr:
					begin
						regWrite = 1'b0;
						jumpSel  = pcReg;        // Target is rs data
					end
					default: regWrite = 1'b0;    // Includes the all-zero word
				endcase
			end
			opAddi: {aluSrc, regWrite} = 2'b11;
			opSlti: {aluSrc, regWrite, aluOp} = {2'b11, aluSlt};
			opAndi: {aluSrc, regWrite, extZero, aluOp} = {3'b111, aluAnd};
			opOri:  {aluSrc, regWrite, extZero, aluOp} = {3'b111, aluOr};
			opXori: {aluSrc, regWrite, extZero, aluOp} = {3'b111, aluXor};
			opLui:  {aluSrc, regWrite, aluOp} = {2'b11, aluLui};
			opLw:   {aluSrc, regWrite, wbSel} = {2'b11, wbMem};
			opSw:   {aluSrc, memWrite} = 2'b11; // Address is rs + offset
			opBeq:  {branchEq, aluOp} = {1'b1, aluSub};
			opBne:  {branchNe, aluOp} = {1'b1, aluSub};
			opJ:    jumpSel = pcJump;
			opJal:
			begin
				jumpSel  = pcJump;
				regDst   = dstRa;                // Link into register 31
				wbSel    = wbLink;
				regWrite = 1'b1;
			end
			default: ;                           // Unknown opcode stays a no-op
		endcase
	end

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu
	import cpuPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	output logic [31:0] pc,
	output instrWord    instr,                   // Fetched word
	output logic        regWriteEn,
	output logic [4:0]  regWriteAddr,
	output logic [31:0] regWriteData,
	output logic        memWriteEn,
	output logic [31:0] memAddr,
	output logic [31:0] memWriteData
);

	logic [1:0]  regDst;                         // Decoder outputs
	logic        aluSrc;
	logic        extZero;
	logic [2:0]  aluOp;
	logic        memWrite;
	logic [1:0]  wbSel;
	logic        regWrite;
	logic        branchEq;
	logic        branchNe;
	logic [1:0]  jumpSel;

	logic [31:0] pcPlus4;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] immExt;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic        zero;
	logic [31:0] readData;

	pcUnit uPcUnit (.clk(clk), .rstN(rstN), .immExt(immExt),
		.jumpTarget(instr.j.target26), .regTarget(rsData), .zero(zero),
		.branchEq(branchEq), .branchNe(branchNe), .jumpSel(jumpSel),
		.pc(pc), .pcPlus4(pcPlus4));

	instMem uInstMem (.addr(pc), .instr(instr));

	control uControl (.op(instr.r.op), .funct(instr.r.funct), .regDst(regDst),
		.aluSrc(aluSrc), .extZero(extZero), .aluOp(aluOp), .memWrite(memWrite),
		.wbSel(wbSel), .regWrite(regWrite), .branchEq(branchEq),
		.branchNe(branchNe), .jumpSel(jumpSel));

	registerFile uRegisterFile (.clk(clk), .rstN(rstN), .rsAddr(instr.r.rs),
		.rtAddr(instr.r.rt), .wrEn(regWrite), .wrAddr(regWriteAddr),
		.wrData(regWriteData), .rsData(rsData), .rtData(rtData));

	// Logical immediates zero-extend, the rest sign-extend
	assign immExt = extZero ? {16'b0, instr.i.imm16}
		: {{16{instr.i.imm16[15]}}, instr.i.imm16};
	assign aluB   = aluSrc ? immExt : rtData;    // ALU B operand

	alu uAlu (.aluOp(aluOp), .a(rsData), .b(aluB), .result(aluResult), .zero(zero));

	dataMemory uDataMemory (.clk(clk), .addr(aluResult), .wrEn(memWrite),
		.wrData(rtData), .readData(readData));

	always_comb
	begin
		case (regDst)
			dstRd:   regWriteAddr = instr.r.rd;
			dstRa:   regWriteAddr = 5'd31;       // jal link
			default: regWriteAddr = instr.i.rt;
		endcase
	end

	always_comb
	begin
		case (wbSel)
			wbMem:   regWriteData = readData;
			wbLink:  regWriteData = pcPlus4;     // Return address
			default: regWriteData = aluResult;
		endcase
	end

	assign regWriteEn   = regWrite;              // Observed by the testbench
	assign memWriteEn   = memWrite;
	assign memAddr      = aluResult;
	assign memWriteData = rtData;

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int instWords = 256;              // Instruction ROM depth in words
	localparam int dataWords = 256;              // Data RAM depth in words
	localparam int instAddrBits = $clog2(instWords); // Word index width of the ROM
	localparam int dataAddrBits = $clog2(dataWords); // Word index width of the RAM

	// Opcodes
	localparam logic [5:0] opRType = 6'h00;      // Funct field selects the operation
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opJal   = 6'h03;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opSlti  = 6'h0a;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opXori  = 6'h0e;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// R-type funct codes
	localparam logic [5:0] fnJr  = 6'h08;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;

	// ALU operations
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr  = 3'd3;
	localparam logic [2:0] aluXor = 3'd4;
	localparam logic [2:0] aluNor = 3'd5;
	localparam logic [2:0] aluSlt = 3'd6;
	localparam logic [2:0] aluLui = 3'd7;        // Immediate into upper half

	localparam logic [1:0] dstRd = 2'd0;         // Write register selects
	localparam logic [1:0] dstRt = 2'd1;
	localparam logic [1:0] dstRa = 2'd2;         // Link register 31

	localparam logic [1:0] wbAlu  = 2'd0;        // Writeback selects
	localparam logic [1:0] wbMem  = 2'd1;
	localparam logic [1:0] wbLink = 2'd2;        // Return address for jal

	localparam logic [1:0] pcSeq  = 2'd0;        // Next PC from adder or branch
	localparam logic [1:0] pcJump = 2'd1;        // Pseudo-direct jump
	localparam logic [1:0] pcReg  = 2'd2;        // Register jump

	// One fetched word, read in the R, I and J formats
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} i;
		struct packed {
			logic [5:0] op;
			logic [25:0] target26;
		} j;
	} instrWord;

endpackage

`default_nettype wire

/* cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTb
	import cpuPkg::*;
();

	localparam int clkPeriod   = 40;
	localparam int resetCycles = 3;
	localparam int runInstrs   = 60;             // Program ends in a jump to itself
	localparam int runLimit    = 120;            // Watchdog limit in cycles

	logic        clk = 1'b0;                     // Low before any process starts
	logic        rstN;
	logic [31:0] pc;
	instrWord    instr;
	logic        regWriteEn;
	logic [4:0]  regWriteAddr;
	logic [31:0] regWriteData;
	logic        memWriteEn;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;

	logic [31:0] progMem [instWords];            // Copy of the program image
	logic [31:0] modelRegs [32];                 // Architectural state of the model
	logic [31:0] modelMem [dataWords];
	logic [31:0] modelPc;

	cpu DUT (.clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .regWriteEn(regWriteEn),
		.regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
		.memWriteEn(memWriteEn), .memAddr(memAddr), .memWriteData(memWriteData));

	initial
	begin
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		rstN = 1'b0;                             // Held low from time 0
		repeat (resetCycles) @(negedge clk);
		rstN <= 1'b1;
	end

	task automatic stopRun();
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		stopRun();
	endtask

	task automatic checkWord(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch on %s at pc %h: got %h, expected %h", name, pc, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkReg(input string name, input logic [4:0] actual,
		input logic [4:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch on %s at pc %h: got %h, expected %h", name, pc, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Mismatch on %s at pc %h: got %h, expected %h", name, pc, actual, expected);
			stopRun();
		end
	endtask

	// Executes one instruction on the model state and returns what the ports should show
	function automatic void stepModel(input instrWord ins, output logic [31:0] expPc,
		output logic expRegEn, output logic [4:0] expRegAddr, output logic [31:0] expRegData,
		output logic expMemEn, output logic [31:0] expMemAddr, output logic [31:0] expMemData);
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] sImm;
		logic [31:0] zImm;
		logic [31:0] effAddr;
		logic [31:0] linkPc;
		logic [31:0] nextPc;
		rsVal   = modelRegs[ins.r.rs];
		rtVal   = modelRegs[ins.r.rt];
		sImm    = {{16{ins.i.imm16[15]}}, ins.i.imm16};
		zImm    = {16'h0000, ins.i.imm16};
		effAddr = rsVal + sImm;                  // lw and sw address
		linkPc  = modelPc + 32'd4;
		nextPc  = linkPc;
		expPc      = modelPc;
		expRegEn   = 1'b0;
		expRegAddr = ins.i.rt;
		expRegData = 32'h0;
		expMemEn   = 1'b0;
		expMemAddr = 32'h0;
		expMemData = 32'h0;
		case (ins.r.op)
			opRType:
			begin
				expRegEn   = 1'b1;
				expRegAddr = ins.r.rd;
				case (ins.r.funct)
					fnAdd: expRegData = rsVal + rtVal;
					fnSub: expRegData = rsVal - rtVal;
					fnAnd: expRegData = rsVal & rtVal;
					fnOr:  expRegData = rsVal | rtVal;
					fnXor: expRegData = rsVal ^ rtVal;
					fnNor: expRegData = ~(rsVal | rtVal);
					fnSlt: expRegData = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
					fnJr:
					begin
						expRegEn = 1'b0;
						nextPc   = rsVal;        // Return through rs
					end
					default: expRegEn = 1'b0;    // Nop and unknown funct
				endcase
			end
			opAddi: {expRegEn, expRegData} = {1'b1, rsVal + sImm};
			opSlti: {expRegEn, expRegData} = {1'b1, 31'd0, $signed(rsVal) < $signed(sImm)};
			opAndi: {expRegEn, expRegData} = {1'b1, rsVal & zImm};
			opOri:  {expRegEn, expRegData} = {1'b1, rsVal | zImm};
			opXori: {expRegEn, expRegData} = {1'b1, rsVal ^ zImm};
			opLui:  {expRegEn, expRegData} = {1'b1, ins.i.imm16, 16'h0000};
			opLw:   {expRegEn, expRegData} = {1'b1, modelMem[effAddr[dataAddrBits+1:2]]};
			opSw:   {expMemEn, expMemAddr, expMemData} = {1'b1, effAddr, rtVal};
			opBeq:  if (rsVal == rtVal) nextPc = linkPc + (sImm << 2);
			opBne:  if (rsVal != rtVal) nextPc = linkPc + (sImm << 2);
			opJ:    nextPc = {linkPc[31:28], ins.j.target26, 2'b00};
			opJal:
			begin
				nextPc     = {linkPc[31:28], ins.j.target26, 2'b00};
				expRegEn   = 1'b1;
				expRegAddr = 5'd31;
				expRegData = linkPc;
			end
			default: ;
		endcase
		if (expRegEn && expRegAddr != 5'd0)
			modelRegs[expRegAddr] = expRegData;  // r0 keeps reading zero
		if (expMemEn)
			modelMem[expMemAddr[dataAddrBits+1:2]] = expMemData;
		modelPc = nextPc;
	endfunction

	task automatic sampleAfterFall();
		@(negedge clk);
		#5;                                      // Outputs settled before the rising edge
	endtask

	task automatic checkStep();
		instrWord    ins;
		logic [31:0] expPc;
		logic        expRegEn;
		logic [4:0]  expRegAddr;
		logic [31:0] expRegData;
		logic        expMemEn;
		logic [31:0] expMemAddr;
		logic [31:0] expMemData;
		ins = progMem[modelPc[instAddrBits+1:2]];
		stepModel(ins, expPc, expRegEn, expRegAddr, expRegData, expMemEn, expMemAddr,
			expMemData);
		checkWord("pc", pc, expPc);
		checkWord("instr", instr, ins);
		checkBit("regWriteEn", regWriteEn, expRegEn);
		if (expRegEn)
		begin
			checkReg("regWriteAddr", regWriteAddr, expRegAddr);
			checkWord("regWriteData", regWriteData, expRegData);
		end
		checkBit("memWriteEn", memWriteEn, expMemEn);
		if (expMemEn)
		begin
			checkWord("memAddr", memAddr, expMemAddr);
			checkWord("memWriteData", memWriteData, expMemData);
		end
	endtask

	initial
	begin : checkProcess
		int waited;
		$readmemh("program.hex", progMem);      // Same image as the ROM
		for (int k = 0; k < 32; k++)
			modelRegs[k] = 32'h0;
		for (int k = 0; k < dataWords; k++)
			modelMem[k] = 32'h0;
		modelPc = 32'h0;
		waited  = 0;
		while (rstN !== 1'b1)                    // PC held at 0 with no writes from the nop
		begin
			sampleAfterFall();
			checkWord("pc", pc, 32'h0);
			checkBit("regWriteEn", regWriteEn, 1'b0);
			checkBit("memWriteEn", memWriteEn, 1'b0);
			waited++;
			if (waited > resetCycles + 2)
				reportFailure("Reset was never released");
		end
		for (int n = 0; n < runInstrs; n++)
		begin
			if (n > 0)
				sampleAfterFall();
			checkStep();
		end
		$display("All tests passed!");
		$finish;
	end

	initial
	begin : watchdog
		for (int t = 0; t < runLimit; t++)
			#(clkPeriod);
		reportFailure("Run did not finish before the watchdog limit");
	end

endmodule

`default_nettype wire

/* dataMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module dataMemory
	import cpuPkg::*;
(
	input  logic        clk,
	input  logic [31:0] addr,                    // Byte address from the ALU
	input  logic        wrEn,
	input  logic [31:0] wrData,
	output logic [31:0] readData
);

	logic [31:0] ram [dataWords];
	logic [dataAddrBits-1:0] wordIndex;

	assign wordIndex = addr[dataAddrBits+1:2];   // Whole words only

	always_ff @(posedge clk)
	begin
		if (wrEn)
			ram[wordIndex] <= wrData;
	end

	// Read data follows the address in the same cycle
	assign readData = ram[wordIndex];

endmodule

`default_nettype wire

/* filelist.f */
cpuPkg.sv
control.sv
alu.sv
registerFile.sv
pcUnit.sv
instMem.sv
dataMemory.sv
cpu.sv
cpuTb.sv

/* instMem.sv */
`timescale 1ns/100ps
`default_nettype none

module instMem
	import cpuPkg::*;
(
	input  logic [31:0] addr,                    // Byte address from the PC
	output logic [31:0] instr
);

	logic [31:0] rom [instWords];
	logic [instAddrBits-1:0] wordIndex;

	initial
	begin
		$readmemh("program.hex", rom);          // One word per line
	end

	assign wordIndex = addr[instAddrBits+1:2];   // Drop the byte offset
	assign instr     = rom[wordIndex];

endmodule

`default_nettype wire

/* pcUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module pcUnit
	import cpuPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] immExt,                  // Branch offset in words
	input  logic [25:0] jumpTarget,
	input  logic [31:0] regTarget,               // rs data for jr
	input  logic        zero,
	input  logic        branchEq,
	input  logic        branchNe,
	input  logic [1:0]  jumpSel,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4
);

	logic [31:0] branchTarget;
	logic        taken;
	logic [31:0] seqNext;                        // After the branch choice
	logic [31:0] pcNext;

	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + (immExt << 2);
	assign taken        = (branchEq && zero) || (branchNe && !zero);
	assign seqNext      = taken ? branchTarget : pcPlus4;

	always_comb
	begin
		case (jumpSel)
			pcJump:  pcNext = {pcPlus4[31:28], jumpTarget, 2'b00};
			pcReg:   pcNext = regTarget;
			default: pcNext = seqNext;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			pc <= '0;                            // Fetch starts at address 0
		else
			pc <= pcNext;
	end

endmodule

`default_nettype wire

/* program.hex */
// One 32-bit instruction word per line in hex, starting at address 0
// Each comment gives the byte address and the instruction
00000000 // 00 nop
20010005 // 04 addi r1, r0, 5
2002FFFD // 08 addi r2, r0, -3
00221820 // 0c add  r3, r1, r2
00222022 // 10 sub  r4, r1, r2
00222824 // 14 and  r5, r1, r2
00223025 // 18 or   r6, r1, r2
00223826 // 1c xor  r7, r1, r2
00224027 // 20 nor  r8, r1, r2
0041482A // 24 slt  r9, r2, r1
0022502A // 28 slt  r10, r1, r2
284BFFFF // 2c slti r11, r2, -1
304CF0F0 // 30 andi r12, r2, 0xf0f0
342D8001 // 34 ori  r13, r1, 0x8001
384EFFFF // 38 xori r14, r2, 0xffff
3C0F1234 // 3c lui  r15, 0x1234
20200007 // 40 addi r0, r1, 7
00018020 // 44 add  r16, r0, r1
AC2F0003 // 48 sw   r15, 3(r1)
AC02000C // 4c sw   r2, 12(r0)
8C310003 // 50 lw   r17, 3(r1)
8C12000C // 54 lw   r18, 12(r0)
122F0001 // 58 beq  r17, r15, +1
20130001 // 5c addi r19, r0, 1
14210001 // 60 bne  r1, r1, +1
20140002 // 64 addi r20, r0, 2
20150003 // 68 addi r21, r0, 3
22B5FFFF // 6c addi r21, r21, -1
16A0FFFE // 70 bne  r21, r0, -2
10220005 // 74 beq  r1, r2, +5
0C000022 // 78 jal  0x88
08000024 // 7c j    0x90
20160009 // 80 addi r22, r0, 9
2016000A // 84 addi r22, r0, 10
23F70004 // 88 addi r23, r31, 4
03E00008 // 8c jr   r31
08000024 // 90 j    0x90

/* registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile
(
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	output logic [31:0] rsData,
	output logic [31:0] rtData
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int k = 0; k < 32; k++)
			begin
				regs[k] <= '0;
			end
		end
		else if (wrEn && wrAddr != 5'd0)         // Register 0 ignores writes
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Reads are combinational; a write shows on the next cycle
	assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire
